/* hw/matrixConfigPkg.sv */
// Matrix unit geometry and widths
`default_nettype none

package matrixConfigPkg;

    // ====================
    // Array geometry
    // ====================

    localparam int arraySizeDefault = 8;    // Rows and columns of the PE grid

    // ====================
    // Element widths
    // ====================

    localparam int weightWidth = 8;         // Signed weight, also the activation lane width
    localparam int actWidth    = 7;         // Unsigned activation before zero extension

    // Partial sum grows by one bit per doubling of the rows it passes
    localparam int sumWidth = weightWidth + actWidth + $clog2(arraySizeDefault);

    // ====================
    // Address widths
    // ====================

    // Element address is row times size plus column
    localparam int elemAddrWidth = $clog2(arraySizeDefault * arraySizeDefault);
    localparam int rowAddrWidth  = $clog2(arraySizeDefault);    // Selects one row

endpackage

`default_nettype wire

/* hw/matrixCtrlPkg.sv */
// Controller states and phase lengths
`default_nettype none

package matrixCtrlPkg;

    // Run order is idle, preload, stream, drain, done
    // Idle and done both take memory writes and a new start
    typedef enum logic [2:0] {
        ctrlIdle,
        ctrlPreload,
        ctrlStream,
        ctrlDrain,
        ctrlDone
    } ctrlState;

    // ====================
    // Phase lengths
    // ====================

    localparam int preloadCycles = matrixConfigPkg::arraySizeDefault;  // One weight row per cycle
    localparam int streamCycles  = matrixConfigPkg::arraySizeDefault;  // One vector per cycle

    // Last vector still has to cross the skew, the array depth and the column delay
    localparam int drainCycles   = 2 * matrixConfigPkg::arraySizeDefault;

endpackage

`default_nettype wire

/* hw/operandMemory.sv */
// Element-write row-read operand memory
`default_nettype none

module operandMemory
    import matrixConfigPkg::*;
#(
    parameter int arraySize = arraySizeDefault,
    parameter int elemWidth = weightWidth
) (
    input  wire                                clk,
    input  wire                                wrEn,     // Already gated by the controller
    input  wire [elemAddrWidth-1:0]            wrAddr,   // Row times size plus column
    input  wire [elemWidth-1:0]                wrData,
    input  wire [rowAddrWidth-1:0]             rdAddr,   // Row index
    output logic [arraySize-1:0][elemWidth-1:0] rdRow    // Registered, one cycle latency
);

    localparam int depth = arraySize * arraySize;

    // ====================
    // Storage
    // ====================

    logic [elemWidth-1:0] mem [depth];

    // Loader fills one element per cycle
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // ====================
    // Row read
    // ====================

    // Whole row leaves in one cycle, lane c is column c
    always_ff @(posedge clk) begin
        for (int col = 0; col < arraySize; col++) begin
            rdRow[col] <= mem[rdAddr * arraySize + col];
        end
    end

endmodule

`default_nettype wire

/* hw/inputSkewBuffer.sv */
// Diagonal activation skew
`default_nettype none

module inputSkewBuffer
    import matrixConfigPkg::*;
#(
    parameter int arraySize = arraySizeDefault
) (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire  [arraySize-1:0][weightWidth-1:0] rowIn,      // Straight from the memory
    input  wire                                   rowValid,
    output logic [arraySize-1:0][weightWidth-1:0] skewedRow   // Lane k delayed by k cycles
);

    logic [arraySize-1:0][weightWidth-1:0] gatedRow;

    // Idle lanes carry zero so the array needs no valid bits
    always_comb begin
        for (int lane = 0; lane < arraySize; lane++) begin
            gatedRow[lane] = rowValid ? rowIn[lane] : '0;
        end
    end

    for (genvar lane = 0; lane < arraySize; lane++) begin : gLane
        if (lane == 0) begin : gDirect
            assign skewedRow[lane] = gatedRow[lane];    // Top row has no delay
        end else begin : gDelay
            logic [weightWidth-1:0] stage [lane];       // Depth equals lane index
            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    for (int i = 0; i < lane; i++) begin
                        stage[i] <= '0;
                    end
                end else begin
                    stage[0] <= gatedRow[lane];
                    for (int i = 1; i < lane; i++) begin
                        stage[i] <= stage[i-1];
                    end
                end
            end
            assign skewedRow[lane] = stage[lane-1];
        end
    end

endmodule

`default_nettype wire

/* hw/processingElement.sv */
// Stationary-weight MAC cell
`default_nettype none

module processingElement
    import matrixConfigPkg::*;
(
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           weightLoad,  // Shift weights down the column
    input  wire signed [weightWidth-1:0]  weightIn,    // From the cell above
    input  wire        [weightWidth-1:0]  actIn,       // From the cell to the left
    input  wire signed [sumWidth-1:0]     sumIn,       // Partial sum from above
    output logic signed [weightWidth-1:0] weightOut,   // Stationary weight, also passed down
    output logic        [weightWidth-1:0] actOut,      // To the right neighbour
    output logic signed [sumWidth-1:0]    sumOut       // To the cell below
);

    logic signed [sumWidth-1:0] product;

    // Activation is non-negative, extend with a zero sign bit
    assign product = weightOut * $signed({1'b0, actIn});

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            weightOut <= '0;
            actOut    <= '0;
            sumOut    <= '0;
        end else begin
            // Old weight moves on to the next row as the new one lands
            if (weightLoad) begin
                weightOut <= weightIn;
            end
            actOut <= actIn;                // One cycle per column
            sumOut <= sumIn + product;      // One cycle per row
        end
    end

endmodule

`default_nettype wire

/* hw/systolicArray.sv */
// Systolic MAC grid
`default_nettype none

module systolicArray
    import matrixConfigPkg::*;
#(
    parameter int arraySize = arraySizeDefault
) (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire                                   weightLoad,
    input  wire  [arraySize-1:0][weightWidth-1:0] weightRow,  // Enters the top edge
    input  wire  [arraySize-1:0][weightWidth-1:0] actRow,     // Enters the left edge, skewed
    output logic [arraySize-1:0][sumWidth-1:0]    sumRow      // Leaves the bottom edge
);

    // ====================
    // Grid nets
    // ====================

    // Index [row][col], one extra entry on the flow direction
    wire signed [weightWidth-1:0] weightNet [arraySize+1][arraySize];
    wire        [weightWidth-1:0] actNet    [arraySize][arraySize+1];
    wire signed [sumWidth-1:0]    sumNet    [arraySize+1][arraySize];

    for (genvar idx = 0; idx < arraySize; idx++) begin : gEdge
        assign weightNet[0][idx]      = weightRow[idx];
        assign actNet[idx][0]         = actRow[idx];
        assign sumNet[0][idx]         = '0;                    // Top edge starts from zero
        assign sumRow[idx]            = sumNet[arraySize][idx];
    end

    // ====================
    // PE instances
    // ====================

    for (genvar row = 0; row < arraySize; row++) begin : gRow
        for (genvar col = 0; col < arraySize; col++) begin : gCol
            processingElement i_processingElement (
                .clk        (clk),
                .rst        (rst),
                .weightLoad (weightLoad),
                .weightIn   (weightNet[row][col]),
                .actIn      (actNet[row][col]),
                .sumIn      (sumNet[row][col]),
                .weightOut  (weightNet[row+1][col]),
                .actOut     (actNet[row][col+1]),
                .sumOut     (sumNet[row+1][col])
            );
        end
    end

endmodule

`default_nettype wire

/* hw/outputAccumulator.sv */
// Staggered result capture
`default_nettype none

module outputAccumulator
    import matrixConfigPkg::*;
#(
    parameter int arraySize = arraySizeDefault
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                accWrEn,     // Enable for column 0
    input  wire [arraySize-1:0][sumWidth-1:0]  sumRow,      // Bottom edge of the array
    input  wire [elemAddrWidth-1:0]            resultAddr,  // Vector times size plus column
    output logic signed [sumWidth-1:0]         resultData   // Combinational read
);

    // ====================
    // Diagonal enables
    // ====================

    logic [arraySize-1:1]      enDly;      // Column c enable, c cycles late
    wire  [arraySize-1:0]      colEn = {enDly, accWrEn};
    logic [rowAddrWidth-1:0]   wrPtr [arraySize];  // Vector index per column

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enDly <= '0;
            for (int col = 0; col < arraySize; col++) begin
                wrPtr[col] <= '0;
            end
        end else begin
            enDly <= colEn[arraySize-2:0];      // Each column one step behind its left
            for (int col = 0; col < arraySize; col++) begin
                // Restart as soon as the enable drops
                wrPtr[col] <= colEn[col] ? wrPtr[col] + 1'b1 : '0;
            end
        end
    end

    // ====================
    // Result store
    // ====================

    logic signed [sumWidth-1:0] store [arraySize * arraySize];

    always_ff @(posedge clk) begin
        for (int col = 0; col < arraySize; col++) begin
            if (colEn[col]) begin
                store[wrPtr[col] * arraySize + col] <= sumRow[col];
            end
        end
    end

    assign resultData = store[resultAddr];  // Held until the next run overwrites it

endmodule

`default_nettype wire

/* hw/matrixController.sv */
// Matrix unit phase sequencer
`default_nettype none

module matrixController
    import matrixConfigPkg::*;
    import matrixCtrlPkg::*;
#(
    parameter int arraySize  = arraySizeDefault,
    parameter int preloadLen = preloadCycles,
    parameter int streamLen  = streamCycles,
    parameter int drainLen   = drainCycles
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      start,         // One-cycle run request
    input  wire                      memWrite,      // Raw strobe from the loader
    output logic                     busy,
    output logic                     done,
    output logic                     writeAllowed,  // Strobe passed on to the memories
    output logic [rowAddrWidth-1:0]  weightRdAddr,
    output logic [rowAddrWidth-1:0]  actRdAddr,
    output logic                     weightLoad,    // Lines up with weight memory output
    output logic                     actValid,      // Lines up with activation memory output
    output logic                     accWrEn        // Capture enable for column 0
);

    localparam int cntWidth = $clog2(drainLen + 1);   // Longest phase sets the counter width

    ctrlState             state;
    logic [cntWidth-1:0]  phaseCnt;     // Cycle within the current phase
    logic [cntWidth-1:0]  phaseLast;    // Final count of the current phase
    logic                 phaseEnd;
    logic                 canStart;

    // ====================
    // Status and write gate
    // ====================

    assign canStart     = (state == ctrlIdle) || (state == ctrlDone);
    assign writeAllowed = memWrite && canStart;   // Writes while running are dropped
    assign busy         = (state == ctrlPreload) || (state == ctrlStream)
                       || (state == ctrlDrain);
    assign done         = (state == ctrlDone);

    // Weight rows go out bottom row first so row k settles in PE row k
    assign weightRdAddr = rowAddrWidth'(arraySize - 1) - phaseCnt[rowAddrWidth-1:0];
    assign actRdAddr    = phaseCnt[rowAddrWidth-1:0];    // Vector 0 upward

    always_comb begin
        case (state)
            ctrlPreload: phaseLast = cntWidth'(preloadLen - 1);
            ctrlStream:  phaseLast = cntWidth'(streamLen - 1);
            default:     phaseLast = cntWidth'(drainLen - 1);
        endcase
    end

    assign phaseEnd = (phaseCnt == phaseLast);

    // ====================
    // Phase FSM
    // ====================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ctrlIdle;
            phaseCnt <= '0;
        end else begin
            // Count only while running, restart at each phase boundary
            phaseCnt <= (busy && !phaseEnd) ? phaseCnt + 1'b1 : '0;
            case (state)
                ctrlIdle, ctrlDone: begin
                    if (start) begin
                        state <= ctrlPreload;
                    end
                end
                ctrlPreload: if (phaseEnd) state <= ctrlStream;
                ctrlStream:  if (phaseEnd) state <= ctrlDrain;
                ctrlDrain:   if (phaseEnd) state <= ctrlDone;
                default:     state <= ctrlIdle;
            endcase
        end
    end

    // Strobes trail the read address by the one-cycle memory latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            weightLoad <= 1'b0;
            actValid   <= 1'b0;
            accWrEn    <= 1'b0;
        end else begin
            weightLoad <= (state == ctrlPreload);
            actValid   <= (state == ctrlStream);
            // Vector 0 leaves column 0 one cycle into drain, then one vector per cycle
            accWrEn    <= (state == ctrlDrain) && (phaseCnt < cntWidth'(arraySize));
        end
    end

endmodule

`default_nettype wire

/* hw/matrixUnit.sv */
// Weight-stationary matrix unit
`default_nettype none

module matrixUnit
    import matrixConfigPkg::*;
    import matrixCtrlPkg::*;
#(
    parameter int arraySize = arraySizeDefault
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       memWrite,     // One element per strobe
    input  wire                       memSelect,    // 0 weight, 1 activation
    input  wire [elemAddrWidth-1:0]   memAddr,
    input  wire [weightWidth-1:0]     memData,
    input  wire                       start,
    output logic                      busy,
    output logic                      done,
    input  wire [elemAddrWidth-1:0]   resultAddr,   // Vector times size plus column
    output logic signed [sumWidth-1:0] resultData
);

    // ====================
    // Internal wiring
    // ====================

    wire                                   writeAllowed;
    wire [rowAddrWidth-1:0]                weightRdAddr;
    wire [rowAddrWidth-1:0]                actRdAddr;
    wire                                   weightLoad;
    wire                                   actValid;
    wire                                   accWrEn;
    wire [arraySize-1:0][weightWidth-1:0]  weightRow;
    wire [arraySize-1:0][weightWidth-1:0]  actRow;
    wire [arraySize-1:0][weightWidth-1:0]  skewedRow;
    wire [arraySize-1:0][sumWidth-1:0]     sumRow;

    // Route the gated strobe to one memory
    wire weightWrEn = writeAllowed && !memSelect;
    wire actWrEn    = writeAllowed && memSelect;

    // Activations are unsigned, stored zero-extended to the lane width
    wire [weightWidth-1:0] actWrData = {{(weightWidth - actWidth){1'b0}}, memData[actWidth-1:0]};

    matrixController #(
        .arraySize    (arraySize),
        .preloadLen   (preloadCycles),
        .streamLen    (streamCycles),
        .drainLen     (drainCycles)
    ) i_matrixController (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .memWrite     (memWrite),
        .busy         (busy),
        .done         (done),
        .writeAllowed (writeAllowed),
        .weightRdAddr (weightRdAddr),
        .actRdAddr    (actRdAddr),
        .weightLoad   (weightLoad),
        .actValid     (actValid),
        .accWrEn      (accWrEn)
    );

    operandMemory #(
        .arraySize (arraySize),
        .elemWidth (weightWidth)
    ) i_weightMemory (
        .clk       (clk),
        .wrEn      (weightWrEn),
        .wrAddr    (memAddr),
        .wrData    (memData),
        .rdAddr    (weightRdAddr),
        .rdRow     (weightRow)
    );

    operandMemory #(
        .arraySize (arraySize),
        .elemWidth (weightWidth)
    ) i_actMemory (
        .clk       (clk),
        .wrEn      (actWrEn),
        .wrAddr    (memAddr),
        .wrData    (actWrData),
        .rdAddr    (actRdAddr),
        .rdRow     (actRow)
    );

    inputSkewBuffer #(
        .arraySize (arraySize)
    ) i_inputSkewBuffer (
        .clk       (clk),
        .rst       (rst),
        .rowIn     (actRow),
        .rowValid  (actValid),
        .skewedRow (skewedRow)
    );

    systolicArray #(
        .arraySize  (arraySize)
    ) i_systolicArray (
        .clk        (clk),
        .rst        (rst),
        .weightLoad (weightLoad),
        .weightRow  (weightRow),
        .actRow     (skewedRow),
        .sumRow     (sumRow)
    );

    outputAccumulator #(
        .arraySize  (arraySize)
    ) i_outputAccumulator (
        .clk        (clk),
        .rst        (rst),
        .accWrEn    (accWrEn),
        .sumRow     (sumRow),
        .resultAddr (resultAddr),
        .resultData (resultData)
    );

endmodule

`default_nettype wire

/* sim/tbMatrixVectors.svh */
// Matrix unit test vectors
`ifndef TB_MATRIX_VECTORS_SVH
`define TB_MATRIX_VECTORS_SVH

    localparam int          elemCount = arraySizeDefault * arraySizeDefault;
    localparam logic [31:0] baseSeed  = 32'd74358;    // Each test adds its own offset

    // ====================
    // Pattern kinds
    // ====================

    localparam int patKeep     = 0;    // Memory keeps what the last test wrote
    localparam int patIdentity = 1;    // Weight 1 on the diagonal and 0 elsewhere
    localparam int patCount    = 2;    // Activation equals its element address
    localparam int patRandom   = 3;    // Drawn from the xorshift stream
    localparam int patExtreme  = 4;    // Weight -128 and activation 127

    // ====================
    // Test table
    // ====================

    // Columns are name, weight kind, activation kind and seed offset
    localparam int numTests = 6;
    localparam string testName [numTests] = '{
        "identityCount", "randomBoth", "extremeValues",
        "randomWeights", "reuseWeights", "rerunAfterBusyWrites"
    };
    localparam int weightKind [numTests] = '{
        patIdentity, patRandom, patExtreme, patRandom, patKeep, patKeep
    };
    localparam int actKind [numTests] = '{
        patCount, patRandom, patExtreme, patCount, patRandom, patKeep
    };
    localparam int seedOffset [numTests] = '{0, 1, 2, 3, 4, 5};

    // Classic 32-bit xorshift on a nonzero state
    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Result for vector v and column j is the sum over k of act[v][k] times weight[k][j]
    function automatic int goldenProduct(input int wgt [elemCount], input int act [elemCount],
                                         input int v, input int j);
        int sum;
        sum = 0;
        for (int k = 0; k < arraySizeDefault; k++) begin
            sum += act[v * arraySizeDefault + k] * wgt[k * arraySizeDefault + j];
        end
        return sum;
    endfunction

`endif

/* sim/tbMatrixUnit.sv */
// Matrix unit testbench
`default_nettype none

module tbMatrixUnit
    import matrixConfigPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    `include "tbMatrixVectors.svh"

    localparam int arraySize     = arraySizeDefault;
    localparam int clkPeriod     = 40;
    localparam int resetCycles   = 3;
    localparam int driveDelay    = 2;                // Inputs change just after the edge
    localparam int loadCycles    = 2 * elemCount;    // Both memories at one element per cycle
    localparam int readoutCycles = elemCount;
    localparam int timeoutCycles = numTests * (loadCycles + 4 * arraySize + readoutCycles) * 2;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       memWrite;
    logic                       memSelect;
    logic [elemAddrWidth-1:0]   memAddr;
    logic [weightWidth-1:0]     memData;
    logic                       start;
    logic                       busy;
    logic                       done;
    logic [elemAddrWidth-1:0]   resultAddr;
    logic signed [sumWidth-1:0] resultData;

    int          weightModel [elemCount];   // What the DUT weight memory should hold
    int          actModel [elemCount];      // Same for the activation memory
    logic [31:0] rngState;
    int          errorCount;
    int          failedTests;
    int          cycleCount;

    matrixUnit #(
        .arraySize  (arraySize)
    ) i_matrixUnit (
        .clk        (clk),
        .rst        (rst),
        .memWrite   (memWrite),
        .memSelect  (memSelect),
        .memAddr    (memAddr),
        .memData    (memData),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .resultAddr (resultAddr),
        .resultData (resultData)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // ====================
    // Watchdog
    // ====================

    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
        $display("Test failures found");
        $finish;
    end

    function automatic logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    task automatic checkValue(input string what, input logic signed [31:0] expected,
                              input logic signed [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %0d, actual %0d", what, expected, actual);
            errorCount++;
        end
    endtask

    // ====================
    // Drivers
    // ====================

    task automatic writeElement(input logic sel, input int addr, input logic [7:0] data);
        @(posedge clk);
        #driveDelay;
        memWrite  = 1'b1;
        memSelect = sel;             // 0 selects weight and 1 activation
        memAddr   = elemAddrWidth'(addr);
        memData   = data;
    endtask

    task automatic loadOperands(input int wKind, input int aKind);
        logic [31:0] rnd;
        for (int i = 0; i < elemCount; i++) begin
            if (wKind != patKeep) begin
                rnd = nextRandom();
                case (wKind)
                    patIdentity: weightModel[i] = (i / arraySize == i % arraySize) ? 1 : 0;
                    patExtreme:  weightModel[i] = -128;
                    default:     weightModel[i] = int'($signed(rnd[7:0]));
                endcase
                writeElement(1'b0, i, 8'(weightModel[i]));
            end
        end
        for (int i = 0; i < elemCount; i++) begin
            if (aKind != patKeep) begin
                rnd = nextRandom();
                case (aKind)
                    patCount:   actModel[i] = i % 128;
                    patExtreme: actModel[i] = 127;
                    default:    actModel[i] = int'(rnd[6:0]);
                endcase
                writeElement(1'b1, i, 8'(actModel[i]));
            end
        end
    endtask

    // Start and then hammer both memories with junk writes until done
    task automatic runUnit(input string name);
        logic [31:0] rnd;
        @(posedge clk);
        #driveDelay;
        memWrite = 1'b0;
        start    = 1'b1;
        @(posedge clk);
        #driveDelay;
        start = 1'b0;
        @(negedge clk);
        checkValue({name, " busy after start"}, 1, busy);
        checkValue({name, " done after start"}, 0, done);
        while (!done) begin
            @(posedge clk);
            #driveDelay;
            if (busy) begin
                rnd       = nextRandom();
                memWrite  = 1'b1;            // Must be dropped by the write gate
                memSelect = rnd[31];
                memAddr   = rnd[8 +: elemAddrWidth];
                memData   = rnd[7:0];
            end else begin
                memWrite = 1'b0;
            end
        end
        memWrite = 1'b0;
        checkValue({name, " busy at done"}, 0, busy);
    endtask

    task automatic readResults(input string name);
        logic signed [31:0] expected;
        logic signed [31:0] actual;
        int                 v;
        int                 j;
        for (int addr = 0; addr < elemCount; addr++) begin
            @(posedge clk);
            #driveDelay;
            resultAddr = elemAddrWidth'(addr);
            @(negedge clk);                  // Read port is combinational
            v        = addr / arraySize;
            j        = addr % arraySize;
            expected = goldenProduct(weightModel, actModel, v, j);
            actual   = resultData;
            checkValue($sformatf("%s result[%0d][%0d]", name, v, j), expected, actual);
        end
    endtask

    // ====================
    // Test sequence
    // ====================

    initial begin
        int testErrors;
        rst         = 1'b1;
        memWrite    = 1'b0;
        memSelect   = 1'b0;
        memAddr     = '0;
        memData     = '0;
        start       = 1'b0;
        resultAddr  = '0;
        errorCount  = 0;
        failedTests = 0;
        rngState    = baseSeed;
        for (int i = 0; i < elemCount; i++) begin
            weightModel[i] = 0;
            actModel[i]    = 0;
        end
        repeat (resetCycles) @(posedge clk);
        #driveDelay;
        rst = 1'b0;
        @(negedge clk);
        checkValue("reset busy", 0, busy);
        checkValue("reset done", 0, done);

        for (int t = 0; t < numTests; t++) begin
            testErrors = errorCount;
            rngState   = baseSeed + seedOffset[t];
            loadOperands(weightKind[t], actKind[t]);
            runUnit(testName[t]);
            readResults(testName[t]);
            if (errorCount == testErrors) begin
                $display("PASS %s", testName[t]);
            end else begin
                failedTests++;
                $display("FAIL %s with %0d errors", testName[t], errorCount - testErrors);
            end
        end

        $display("Summary: %0d tests, %0d failed, %0d check errors",
                 numTests, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+sim
hw/matrixConfigPkg.sv
hw/matrixCtrlPkg.sv
hw/operandMemory.sv
hw/inputSkewBuffer.sv
hw/processingElement.sv
hw/systolicArray.sv
hw/outputAccumulator.sv
hw/matrixController.sv
hw/matrixUnit.sv
sim/tbMatrixUnit.sv

/* Bender.yml */
package:
  name: matrix_unit

sources:
  # Design, packages first
  - files:
      - hw/matrixConfigPkg.sv
      - hw/matrixCtrlPkg.sv
      - hw/operandMemory.sv
      - hw/inputSkewBuffer.sv
      - hw/processingElement.sv
      - hw/systolicArray.sv
      - hw/outputAccumulator.sv
      - hw/matrixController.sv
      - hw/matrixUnit.sv

  # Testbench
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tbMatrixUnit.sv
